// File: Makefile
SRCS := $(wildcard design/*.sv design/*.svh testbench/*.sv)

obj_dir/Vmemory_ram_tb: memory_ram.f $(SRCS)
	verilator --binary --timing --top-module memory_ram_tb -f memory_ram.f

run: obj_dir/Vmemory_ram_tb
	@out=$$(./obj_dir/Vmemory_ram_tb); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: design/cache_line_pkg.sv
// cache line type and the read and write port types of the caches
`include "memory_ram_config.svh"

package cache_line_pkg;

    // --------------------
    // stored line
    // --------------------

    // 54 bits: valid at the top, data word at the bottom
    typedef struct packed {
        logic                  valid;
        logic [`MEM_TAG_W-1:0] tag;   // upper address bits
        logic [31:0]           data;
    } cache_line_t;

    // --------------------
    // port requests
    // --------------------

    // read request, sampled every cycle
    typedef struct packed {
        logic [`MEM_CACHE_AW-1:0] addr;
    } cache_rd_t;

    // write request, 64 bits in all
    typedef struct packed {
        logic                     en;    // single-cycle strobe
        logic [`MEM_CACHE_AW-1:0] addr;
        cache_line_t              line;
    } cache_wr_t;

endpackage

// File: design/cache_ram_pair.sv
// two cache line banks with fetch/data swap and same-cycle write forwarding
`timescale 1ns/1ps
`include "memory_ram_config.svh"

module cache_ram_pair (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        swap,       // reverses the bank routing

    // fetch cache
    input  cache_line_pkg::cache_rd_t   fetch_rd,
    input  cache_line_pkg::cache_wr_t   fetch_wr,
    output cache_line_pkg::cache_line_t fetch_q,

    // data cache
    input  cache_line_pkg::cache_rd_t   data_rd,
    input  cache_line_pkg::cache_wr_t   data_wr,
    output cache_line_pkg::cache_line_t data_q
);

    // index 0 is bank 1, index 1 is bank 2
    cache_line_pkg::cache_rd_t   bank_rd   [2];
    cache_line_pkg::cache_wr_t   bank_wr   [2];
    cache_line_pkg::cache_line_t bank_line [2];
    logic                        swap_reg;

    // --------------------
    // request routing
    // --------------------

    // swap low: data cache on bank 1, fetch cache on bank 2
    assign bank_rd[0] = swap ? fetch_rd : data_rd;
    assign bank_wr[0] = swap ? fetch_wr : data_wr;
    assign bank_rd[1] = swap ? data_rd  : fetch_rd;
    assign bank_wr[1] = swap ? data_wr  : fetch_wr;

    // routing that applied when the read was issued
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            swap_reg <= 1'b0;
        end else begin
            swap_reg <= swap;
        end
    end

    // --------------------
    // banks
    // --------------------

    for (genvar b = 0; b < 2; b++) begin : bank_gen
        cache_line_pkg::cache_line_t ram_q;
        cache_line_pkg::cache_line_t wr_line_reg;
        logic [`MEM_CACHE_AW-1:0]    rd_addr_reg;
        logic [`MEM_CACHE_AW-1:0]    wr_addr_reg;
        logic                        wr_en_reg;

        simple_dual_ram #(
            .width   ($bits(cache_line_pkg::cache_line_t)),
            .addr_w  (`MEM_CACHE_AW)
        ) ram_inst (
            .clk     (clk),
            .rd_addr (bank_rd[b].addr),
            .q       (ram_q),
            .wr_addr (bank_wr[b].addr),
            .wr_en   (bank_wr[b].en),
            .wr_data (bank_wr[b].line)
        );

        // control side of the forwarding compare
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                rd_addr_reg <= '0;
                wr_en_reg   <= 1'b0;
            end else begin
                rd_addr_reg <= bank_rd[b].addr;
                wr_en_reg   <= bank_wr[b].en;
            end
        end

        always_ff @(posedge clk) begin
            wr_addr_reg <= bank_wr[b].addr;
            wr_line_reg <= bank_wr[b].line;
        end

        // the RAM returns old data on a collision, so bypass it
        assign bank_line[b] = (wr_en_reg && (wr_addr_reg == rd_addr_reg)) ?
                              wr_line_reg : ram_q;
    end

    // --------------------
    // result routing
    // --------------------

    assign data_q  = swap_reg ? bank_line[1] : bank_line[0];
    assign fetch_q = swap_reg ? bank_line[0] : bank_line[1];

endmodule

// File: design/memory_ram.sv
// memory-side top: cache bank pair, RAM request FIFO and queued-write counter
`timescale 1ns/1ps
`include "memory_ram_config.svh"

module memory_ram (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        swap,

    // cache ports
    input  cache_line_pkg::cache_rd_t   fetch_rd,
    input  cache_line_pkg::cache_rd_t   data_rd,
    input  cache_line_pkg::cache_wr_t   fetch_wr,
    input  cache_line_pkg::cache_wr_t   data_wr,
    output cache_line_pkg::cache_line_t fetch_q,
    output cache_line_pkg::cache_line_t data_q,

    // RAM request queue
    input  logic                        req_push,
    input  logic                        req_pop,
    input  ram_req_pkg::ram_req_t       req_in,
    output ram_req_pkg::ram_req_t       req_q,
    output logic                        req_empty,
    output logic                        req_full,

    output logic [`MEM_WCNT_W-1:0]      write_count   // drains the write buffer
);

    localparam logic [`MEM_WCNT_W-1:0] wcnt_one = 1;

    logic push_wr;
    logic pop_wr;

    // --------------------
    // cache banks
    // --------------------

    cache_ram_pair pair_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .swap     (swap),
        .fetch_rd (fetch_rd),
        .fetch_wr (fetch_wr),
        .fetch_q  (fetch_q),
        .data_rd  (data_rd),
        .data_wr  (data_wr),
        .data_q   (data_q)
    );

    // --------------------
    // request queue
    // --------------------

    request_fifo fifo_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (req_push),
        .pop   (req_pop),
        .din   (req_in),
        .q     (req_q),
        .empty (req_empty),
        .full  (req_full),
        .used  ()              // occupancy stays internal
    );

    // --------------------
    // write counter
    // --------------------

    // only requests the FIFO really takes or releases
    assign push_wr = req_push && !req_full && (req_in.op == ram_req_pkg::RAM_OP_WRITE);
    assign pop_wr  = req_pop && !req_empty && (req_q.op == ram_req_pkg::RAM_OP_WRITE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_count <= '0;
        end else if (push_wr && !pop_wr) begin
            write_count <= write_count + wcnt_one;
        end else if (pop_wr && !push_wr) begin
            write_count <= write_count - wcnt_one;
        end
    end

endmodule

// File: design/memory_ram_config.svh
// width and depth macros for the cache banks, request FIFO and write counter
`ifndef MEMORY_RAM_CONFIG_SVH
`define MEMORY_RAM_CONFIG_SVH

// --------------------
// cache line stores
// --------------------

// index into one 512-entry bank
`define MEM_CACHE_AW 9

// tag bits kept per line
`define MEM_TAG_W 21

// --------------------
// RAM request queue
// --------------------

// pointer width, 16 entries
`define MEM_FIFO_AW 4

// queued write requests, counts up to the full depth
`define MEM_WCNT_W 5

`endif

// File: design/ram_req_pkg.sv
// opcode enum and request struct for the outgoing RAM request queue
package ram_req_pkg;

    // --------------------
    // opcode
    // --------------------

    // one bit, sits at the top of the request
    typedef enum logic {
        RAM_OP_READ  = 1'b0,
        RAM_OP_WRITE = 1'b1
    } ram_op_e;

    // --------------------
    // request
    // --------------------

    // 67 bits
    //   op       [66]
    //   address  [65:36]  word address
    //   value    [35:4]
    //   byteena  [3:0]    zero asks for a four-word burst
    typedef struct packed {
        ram_op_e     op;
        logic [29:0] address;  // word aligned
        logic [31:0] value;    // write data, unused on reads
        logic [3:0]  byteena;
    } ram_req_t;

endpackage

// File: design/request_fifo.sv
// show-ahead request FIFO with registered full and empty flags and a used count
`timescale 1ns/1ps
`include "memory_ram_config.svh"

module request_fifo (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     push,
    input  logic                     pop,
    input  ram_req_pkg::ram_req_t    din,

    output ram_req_pkg::ram_req_t    q,
    output logic                     empty,
    output logic                     full,
    output logic [`MEM_FIFO_AW:0]    used
);

    localparam logic [`MEM_FIFO_AW:0]   depth   = 1 << `MEM_FIFO_AW;
    localparam logic [`MEM_FIFO_AW:0]   cnt_one = 1;
    localparam logic [`MEM_FIFO_AW-1:0] ptr_one = 1;

    ram_req_pkg::ram_req_t     mem [0:(1 << `MEM_FIFO_AW)-1];
    logic [`MEM_FIFO_AW-1:0]   wr_ptr;
    logic [`MEM_FIFO_AW-1:0]   rd_ptr;
    logic [`MEM_FIFO_AW:0]     count;
    logic [`MEM_FIFO_AW:0]     count_next;
    logic                      push_ok;
    logic                      pop_ok;

    assign push_ok = push && !full;   // full queue drops the push
    assign pop_ok  = pop && !empty;   // empty queue drops the pop

    // --------------------
    // occupancy
    // --------------------

    always_comb begin
        case ({push_ok, pop_ok})
            2'b10:   count_next = count + cnt_one;
            2'b01:   count_next = count - cnt_one;
            default: count_next = count;   // idle, or push and pop together
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            empty <= 1'b1;
            full  <= 1'b0;
        end else begin
            count <= count_next;
            empty <= (count_next == '0);       // flags track the new count
            full  <= (count_next == depth);
        end
    end

    // --------------------
    // pointers and storage
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + ptr_one;   // wraps at depth
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + ptr_one;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    // head entry is always on q
    assign q    = mem[rd_ptr];
    assign used = count;

endmodule

// File: design/simple_dual_ram.sv
// simple dual-port RAM, one registered read port and one write port
`timescale 1ns/1ps

module simple_dual_ram #(
    parameter int width  = 8,
    parameter int addr_w = 4
) (
    input  logic              clk,

    // read port
    input  logic [addr_w-1:0] rd_addr,
    output logic [width-1:0]  q,

    // write port
    input  logic [addr_w-1:0] wr_addr,
    input  logic              wr_en,
    input  logic [width-1:0]  wr_data
);

    localparam int depth = 1 << addr_w;

    logic [width-1:0] mem [0:depth-1];

    // --------------------
    // write port
    // --------------------

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // --------------------
    // read port
    // --------------------

    // same-address collision returns the old word
    always_ff @(posedge clk) begin
        q <= mem[rd_addr];
    end

endmodule

// File: memory_ram.f
+incdir+design
design/cache_line_pkg.sv
design/ram_req_pkg.sv
design/simple_dual_ram.sv
design/request_fifo.sv
design/cache_ram_pair.sv
design/memory_ram.sv
testbench/memory_ram_sva.sv
testbench/memory_ram_checker.sv
testbench/memory_ram_tb.sv

// File: testbench/memory_ram_checker.sv
// reference models of the banks and the request queue, per-cycle comparison and error counts
`timescale 1ns/1ps
`include "memory_ram_config.svh"

module memory_ram_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        swap,
    input  cache_line_pkg::cache_rd_t   fetch_rd,
    input  cache_line_pkg::cache_rd_t   data_rd,
    input  cache_line_pkg::cache_wr_t   fetch_wr,
    input  cache_line_pkg::cache_wr_t   data_wr,
    input  cache_line_pkg::cache_line_t fetch_q,
    input  cache_line_pkg::cache_line_t data_q,
    input  logic                        req_push,
    input  logic                        req_pop,
    input  ram_req_pkg::ram_req_t       req_in,
    input  ram_req_pkg::ram_req_t       req_q,
    input  logic                        req_empty,
    input  logic                        req_full,
    input  logic [`MEM_WCNT_W-1:0]      write_count,
    output int                          error_count,
    output int                          check_count
);

    localparam int fifo_depth = 1 << `MEM_FIFO_AW;

    // index 0 is bank 1
    cache_line_pkg::cache_line_t bank_mem [2][1 << `MEM_CACHE_AW];
    bit                          bank_set [2][1 << `MEM_CACHE_AW];
    ram_req_pkg::ram_req_t       queue_model [$];
    int                          write_tally = 0;   // queued write requests
    cache_line_pkg::cache_line_t exp_data;
    cache_line_pkg::cache_line_t exp_fetch;
    bit                          data_known = 1'b0;
    bit                          fetch_known = 1'b0;
    int                          errors = 0;
    int                          checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // expected line after the edge with same-address writes forwarded
    function automatic cache_line_pkg::cache_line_t predict_line(input bit bank,
        input cache_line_pkg::cache_rd_t rd, input cache_line_pkg::cache_wr_t wr);
        if (wr.en && wr.addr == rd.addr) begin
            return wr.line;
        end
        return bank_mem[bank][rd.addr];
    endfunction

    function automatic bit line_known(input bit bank,
        input cache_line_pkg::cache_rd_t rd, input cache_line_pkg::cache_wr_t wr);
        return (wr.en && wr.addr == rd.addr) || bank_set[bank][rd.addr];
    endfunction

    task automatic record_check(input bit ok, input string what, input string got,
                                input string exp);
        checks++;
        if (!ok) begin
            errors++;
            $display("FAIL %0t: %s is %s, expected %s", $time, what, got, exp);
        end
    endtask

    // outputs due after the previous edge, still held at this one
    task automatic compare_outputs();
        if (data_known) begin
            record_check(data_q === exp_data, "data_q",
                         $sformatf("%h", data_q), $sformatf("%h", exp_data));
        end
        if (fetch_known) begin
            record_check(fetch_q === exp_fetch, "fetch_q",
                         $sformatf("%h", fetch_q), $sformatf("%h", exp_fetch));
        end
        record_check(req_empty === (queue_model.size() == 0), "req_empty",
                     $sformatf("%b", req_empty), $sformatf("%b", queue_model.size() == 0));
        record_check(req_full === (queue_model.size() == fifo_depth), "req_full",
                     $sformatf("%b", req_full), $sformatf("%b", queue_model.size() == fifo_depth));
        record_check(write_count === `MEM_WCNT_W'(write_tally), "write_count",
                     $sformatf("%0d", write_count), $sformatf("%0d", write_tally));
        if (queue_model.size() != 0) begin
            record_check(req_q === queue_model[0], "req_q",
                         $sformatf("%h", req_q), $sformatf("%h", queue_model[0]));
        end
    endtask

    // --------------------
    // comparison and model update
    // --------------------
    always @(posedge clk or negedge rst_n) begin
        bit db;
        bit fb;
        bit push_ok;
        bit pop_ok;
        if (!rst_n) begin
            queue_model.delete();
            write_tally = 0;
            data_known  = 1'b0;
            fetch_known = 1'b0;
        end else begin
            compare_outputs();
            db = swap;   // swap low puts the data cache on bank 1
            fb = !swap;
            exp_data    = predict_line(db, data_rd, data_wr);
            exp_fetch   = predict_line(fb, fetch_rd, fetch_wr);
            data_known  = line_known(db, data_rd, data_wr);
            fetch_known = line_known(fb, fetch_rd, fetch_wr);
            if (data_wr.en) begin
                bank_mem[db][data_wr.addr] = data_wr.line;
                bank_set[db][data_wr.addr] = 1'b1;
            end
            if (fetch_wr.en) begin
                bank_mem[fb][fetch_wr.addr] = fetch_wr.line;
                bank_set[fb][fetch_wr.addr] = 1'b1;
            end
            push_ok = req_push && queue_model.size() < fifo_depth;
            pop_ok  = req_pop && queue_model.size() != 0;
            if (pop_ok) begin
                if (queue_model[0].op == ram_req_pkg::RAM_OP_WRITE) write_tally--;
                void'(queue_model.pop_front());
            end
            if (push_ok) begin
                queue_model.push_back(req_in);
                if (req_in.op == ram_req_pkg::RAM_OP_WRITE) write_tally++;
            end
        end
    end

endmodule

// File: testbench/memory_ram_sva.sv
// concurrent assertions on the request FIFO flags, its occupancy and the queued-write count
`timescale 1ns/1ps
`include "memory_ram_config.svh"

module memory_ram_sva (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   empty,
    input logic                   full,
    input logic [`MEM_FIFO_AW:0]  used,
    input logic [`MEM_WCNT_W-1:0] write_count
);

    localparam logic [`MEM_FIFO_AW:0] depth = 1 << `MEM_FIFO_AW;

    int assert_failures = 0;

    flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(full && empty))
        else begin
            assert_failures++;
            $error("request FIFO shows full and empty at once");
        end

    used_in_range: assert property (@(posedge clk) disable iff (!rst_n) used <= depth)
        else begin
            assert_failures++;
            $error("request FIFO occupancy above its depth");
        end

    writes_within_used: assert property (@(posedge clk) disable iff (!rst_n) write_count <= used)
        else begin
            assert_failures++;
            $error("queued write count above FIFO occupancy");
        end

endmodule

// occupancy is taken from inside the FIFO instance
bind memory_ram memory_ram_sva sva_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .empty       (req_empty),
    .full        (req_full),
    .used        (fifo_inst.used),
    .write_count (write_count)
);

// File: testbench/memory_ram_tb.sv
// clock, reset, cache and request queue stimulus, DUT and checker instances
`timescale 1ns/1ps
`include "memory_ram_config.svh"

module memory_ram_tb;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        swap;
    cache_line_pkg::cache_rd_t   fetch_rd;
    cache_line_pkg::cache_rd_t   data_rd;
    cache_line_pkg::cache_wr_t   fetch_wr;
    cache_line_pkg::cache_wr_t   data_wr;
    cache_line_pkg::cache_line_t fetch_q;
    cache_line_pkg::cache_line_t data_q;
    logic                        req_push;
    logic                        req_pop;
    ram_req_pkg::ram_req_t       req_in;
    ram_req_pkg::ram_req_t       req_q;
    logic                        req_empty;
    logic                        req_full;
    logic [`MEM_WCNT_W-1:0]      write_count;
    int                          error_count;
    int                          check_count;
    int                          seed = 25282;
    bit                          timed_out = 1'b0;

    memory_ram memory_ram_inst (.*);
    memory_ram_checker checker_inst (.*);

    always #20 clk = ~clk;   // 40 ns period

    function automatic cache_line_pkg::cache_line_t make_line();
        cache_line_pkg::cache_line_t line;
        line.valid = 1'b1;
        line.tag   = `MEM_TAG_W'($random(seed));
        line.data  = $random(seed);
        return line;
    endfunction

    function automatic ram_req_pkg::ram_req_t make_request();
        ram_req_pkg::ram_req_t req;
        req.op      = (($random(seed) & 1) != 0) ? ram_req_pkg::RAM_OP_WRITE
                                                 : ram_req_pkg::RAM_OP_READ;
        req.address = 30'($random(seed));
        req.value   = $random(seed);
        req.byteena = 4'($random(seed));
        return req;
    endfunction

    // one-cycle write strobe on one cache port
    task automatic cache_write(input bit on_data, input logic [`MEM_CACHE_AW-1:0] addr);
        cache_line_pkg::cache_wr_t wr;
        wr = {1'b1, addr, make_line()};
        if (on_data) data_wr = wr;
        else fetch_wr = wr;
        @(negedge clk);
        data_wr.en  = 1'b0;
        fetch_wr.en = 1'b0;
    endtask

    // push or pop until the matching flag shows up
    task automatic wait_queue_flag(input bit want_full, input int limit);
        int n;
        n = 0;
        while ((want_full ? !req_full : !req_empty) && n < limit) begin
            req_push = want_full;
            req_pop  = !want_full;
            req_in   = make_request();
            @(negedge clk);
            n++;
        end
        req_push = 1'b0;
        req_pop  = 1'b0;
        if (want_full ? !req_full : !req_empty) begin
            $display("timeout: request queue %s flag not seen within %0d cycles",
                     want_full ? "full" : "empty", limit);
            timed_out = 1'b1;
        end
    endtask

    // mixed cache and queue traffic where push_level 4 always pushes
    task automatic random_traffic(input int cycles, input int push_level);
        for (int i = 0; i < cycles; i++) begin
            swap          = ($random(seed) & 7) == 0;
            req_push      = ($random(seed) & 3) < push_level;
            req_pop       = ($random(seed) & 3) < (4 - push_level);
            req_in        = make_request();
            data_rd.addr  = `MEM_CACHE_AW'($random(seed) & 15);
            fetch_rd.addr = `MEM_CACHE_AW'($random(seed) & 15);
            data_wr  = {($random(seed) & 3) == 0, `MEM_CACHE_AW'($random(seed) & 15), make_line()};
            fetch_wr = {($random(seed) & 3) == 0, `MEM_CACHE_AW'($random(seed) & 15), make_line()};
            @(negedge clk);
        end
        {req_push, req_pop, swap, data_wr.en, fetch_wr.en} = '0;
    endtask

    initial begin
        rst_n    = 1'b0;
        swap     = 1'b0;
        fetch_rd = '0;
        data_rd  = '0;
        fetch_wr = '0;
        data_wr  = '0;
        req_push = 1'b0;
        req_pop  = 1'b0;
        req_in   = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // --------------------
        // cache ports
        // --------------------
        for (int i = 0; i < 8; i++) begin
            cache_write(1'b1, `MEM_CACHE_AW'(i));
            cache_write(1'b0, `MEM_CACHE_AW'(i));
        end
        for (int i = 0; i < 8; i++) begin
            data_rd.addr  = `MEM_CACHE_AW'(i);
            fetch_rd.addr = `MEM_CACHE_AW'(7 - i);
            @(negedge clk);
        end
        cache_write(1'b1, 9'h040);   // lands in bank 1
        cache_write(1'b0, 9'h041);   // lands in bank 2
        swap          = 1'b1;
        fetch_rd.addr = 9'h040;
        data_rd.addr  = 9'h041;
        @(negedge clk);
        swap          = 1'b0;
        data_rd.addr  = 9'h080;      // read and write on the same edge
        cache_write(1'b1, 9'h080);
        fetch_rd.addr = 9'h081;
        cache_write(1'b0, 9'h081);

        // --------------------
        // request queue
        // --------------------
        wait_queue_flag(1'b1, 40);
        if (!timed_out) begin
            req_push = 1'b1;         // dropped while the queue is full
            repeat (3) @(negedge clk);
            wait_queue_flag(1'b0, 40);
        end
        if (!timed_out) begin
            req_pop = 1'b1;          // dropped while the queue is empty
            repeat (3) @(negedge clk);
            random_traffic(150, 3);
            random_traffic(150, 1);
            wait_queue_flag(1'b0, 40);
        end
        @(posedge clk);
        @(negedge clk);
        $display("checks: %0d  errors: %0d  assertion failures: %0d", check_count,
                 error_count, memory_ram_inst.sva_inst.assert_failures);
        if (timed_out || error_count != 0 || memory_ram_inst.sva_inst.assert_failures != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule
